//--- design/csr_access_if.sv
// Interfaces: shared CSR access bus and interrupt status link between trap and IRQ units
`timescale 1ns/1ps

interface csr_access_if;
	import csr_map_pkg::*;
	import csr_trap_pkg::*;

	csr_addr_t  addr;  // CSR number
	xlen_t      wdata; // Operand of the CSR instruction
	logic       wen;   // Single-cycle write strobe
	logic       ren;   // Single-cycle read strobe
	csr_wtype_e wtype; // Write, set or clear

	modport source (output addr, wdata, wen, ren, wtype);
	modport bank   (input  addr, wdata, wen, ren, wtype);
endinterface

interface irq_status_if;
	import csr_trap_pkg::*;

	xlen_t       mie;         // Enable mask from trap unit
	logic        mstatus_mie; // Global enable
	xlen_t       mip;         // Pending word from IRQ unit
	logic        irq_active;  // Enabled interrupt waiting
	cause_code_t irq_cause;   // Its mcause code

	modport trap (output mie, mstatus_mie, input mip, irq_active, irq_cause);
	modport irq  (input mie, mstatus_mie, output mip, irq_active, irq_cause);
endinterface

//--- design/csr_counters.sv
// Cycle and retired-instruction counters with mcountinhibit
`timescale 1ns/1ps

module csr_counters (
	input  logic                clk,
	input  logic                rst_n,
	csr_access_if.bank          bus,
	input  logic                instr_ret,
	output csr_trap_pkg::xlen_t rdata,
	output logic                hit
);
	import csr_map_pkg::*;
	import csr_trap_pkg::*;

	logic [63:0] ctr [2];   // 0 mcycle, 1 minstret
	logic        inh_cy;    // mcountinhibit.cy
	logic        inh_ir;    // mcountinhibit.ir
	logic [1:0]  ctr_inc;
	logic        ctr_sel;   // addr bit 1 picks the counter
	logic        ctr_hi;    // addr bit 7 picks the upper half
	logic        is_ctr;
	xlen_t       ctr_half, ctr_wr_val, inh_rd, inh_wr;

	assign ctr_sel    = bus.addr[1];
	assign ctr_hi     = bus.addr[7];
	assign ctr_half   = ctr_hi ? ctr[ctr_sel][63:32] : ctr[ctr_sel][31:0];
	assign ctr_wr_val = csr_wr_merge(ctr_half, bus.wdata, bus.wtype, 32'hffff_ffff);
	assign inh_rd     = {29'b0, inh_ir, 1'b0, inh_cy};
	assign inh_wr     = csr_wr_merge(inh_rd, bus.wdata, bus.wtype, 32'h0000_0005);
	assign ctr_inc    = {!inh_ir && instr_ret, !inh_cy};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctr[0] <= '0;
			ctr[1] <= '0;
			inh_cy <= 1'b0;
			inh_ir <= 1'b0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (ctr_inc[i])
					ctr[i] <= ctr[i] + 64'd1;
			end
			// Software write of one half overrides the count
			if (bus.wen && is_ctr) begin
				if (ctr_hi)
					ctr[ctr_sel][63:32] <= ctr_wr_val;
				else
					ctr[ctr_sel][31:0] <= ctr_wr_val;
			end
			if (bus.wen && bus.addr == ADDR_MCOUNTINHIBIT) begin
				inh_ir <= inh_wr[2];
				inh_cy <= inh_wr[0];
			end
		end
	end

	always_comb begin
		rdata  = '0;
		hit    = 1'b1;
		is_ctr = 1'b0;
		case (bus.addr)
			ADDR_MCYCLE, ADDR_MINSTRET, ADDR_MCYCLEH, ADDR_MINSTRETH: begin
				rdata  = ctr_half;
				is_ctr = 1'b1;
			end
			ADDR_MCOUNTINHIBIT: rdata = inh_rd;
			default:            hit   = 1'b0;
		endcase
	end

endmodule

//--- design/csr_irq_ctrl.sv
// Interrupt input sampling, meie0, meip0, mip, mlei and interrupt prioritisation
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_irq_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	csr_access_if.bank              bus,
	irq_status_if.irq               irqs,
	input  logic [`CSR_NUM_IRQ-1:0] irq,
	input  logic                    irq_software,
	input  logic                    irq_timer,
	output csr_trap_pkg::xlen_t     rdata,
	output logic                    hit
);
	import csr_map_pkg::*;
	import csr_trap_pkg::*;

	localparam xlen_t MEIE0_WMASK = ~({32{1'b1}} << `CSR_NUM_IRQ); // Implemented lines only

	logic [`CSR_NUM_IRQ-1:0] irq_r;
	logic                    irq_software_r;
	logic                    irq_timer_r;
	xlen_t                   meie0;
	xlen_t                   meip0;
	xlen_t                   ext_pend; // Pending and enabled
	xlen_t                   mip;
	xlen_t                   std_pend; // mip masked by mie
	irq_num_t                mlei;

	// Lowest set bit wins
	function automatic irq_num_t lowest_set(input xlen_t v);
		irq_num_t num;
		num = '0;
		for (int i = 31; i >= 0; i--) begin
			if (v[i])
				num = irq_num_t'(i);
		end
		return num;
	endfunction

	// One register stage on all level inputs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r          <= '0;
			irq_software_r <= 1'b0;
			irq_timer_r    <= 1'b0;
			meie0          <= '0;
		end else begin
			irq_r          <= irq;
			irq_software_r <= irq_software;
			irq_timer_r    <= irq_timer;
			if (bus.wen && bus.addr == ADDR_MEIE0)
				meie0 <= csr_wr_merge(meie0, bus.wdata, bus.wtype, MEIE0_WMASK);
		end
	end

	// --------------------------------------------------
	// Pending state and priority
	// --------------------------------------------------
	assign meip0    = xlen_t'(irq_r);
	assign ext_pend = meie0 & meip0;
	assign mlei     = lowest_set(ext_pend);
	assign mip      = {20'b0, |ext_pend, 3'b0, irq_timer_r, 3'b0, irq_software_r, 3'b0};
	assign std_pend = mip & irqs.mie;

	assign irqs.mip        = mip;
	assign irqs.irq_active = |std_pend && irqs.mstatus_mie;
	assign irqs.irq_cause  = cause_code_t'(lowest_set(std_pend)); // msip 3, mtip 7, meip 11

	always_comb begin
		rdata = '0;
		hit   = 1'b1;
		case (bus.addr)
			ADDR_MEIE0: rdata = meie0;
			ADDR_MEIP0: begin
				rdata = meip0;
				hit   = !bus.wen; // Read only
			end
			ADDR_MLEI: begin
				rdata = xlen_t'(mlei);
				hit   = !bus.wen; // Read only
			end
			default: hit = 1'b0;
		endcase
	end

endmodule

//--- design/csr_map_pkg.sv
// CSR address map, write update types, mie write mask and the masked update function
package csr_map_pkg;

	typedef logic [11:0] csr_addr_t; // CSR address space

	typedef enum logic [1:0] {
		wtype_write = 2'h0, // csrrw
		wtype_set   = 2'h1, // csrrs
		wtype_clear = 2'h2  // csrrc
	} csr_wtype_e;

	// Machine information
	localparam csr_addr_t ADDR_MVENDORID     = 12'hf11;
	localparam csr_addr_t ADDR_MARCHID       = 12'hf12;
	localparam csr_addr_t ADDR_MIMPID        = 12'hf13;
	localparam csr_addr_t ADDR_MHARTID       = 12'hf14;
	// Trap setup and handling
	localparam csr_addr_t ADDR_MSTATUS       = 12'h300;
	localparam csr_addr_t ADDR_MIE           = 12'h304;
	localparam csr_addr_t ADDR_MTVEC         = 12'h305;
	localparam csr_addr_t ADDR_MSCRATCH      = 12'h340;
	localparam csr_addr_t ADDR_MEPC          = 12'h341;
	localparam csr_addr_t ADDR_MCAUSE        = 12'h342;
	localparam csr_addr_t ADDR_MTVAL         = 12'h343;
	localparam csr_addr_t ADDR_MIP           = 12'h344;
	// Counters
	localparam csr_addr_t ADDR_MCOUNTINHIBIT = 12'h320;
	localparam csr_addr_t ADDR_MCYCLE        = 12'hb00;
	localparam csr_addr_t ADDR_MINSTRET      = 12'hb02;
	localparam csr_addr_t ADDR_MCYCLEH       = 12'hb80;
	localparam csr_addr_t ADDR_MINSTRETH     = 12'hb82;
	// Custom external interrupt registers
	localparam csr_addr_t ADDR_MEIE0         = 12'hbe0;
	localparam csr_addr_t ADDR_MEIP0         = 12'hfe0;
	localparam csr_addr_t ADDR_MLEI          = 12'hfe4;

	localparam logic [31:0] MIE_WMASK = 32'h0000_0888; // meie, mtie, msie

	// Write, set or clear, then keep the bits outside wmask
	function automatic logic [31:0] csr_wr_merge(
		input logic [31:0] prev,
		input logic [31:0] wdata,
		input csr_wtype_e  wtype,
		input logic [31:0] wmask
	);
		logic [31:0] nxt;
		case (wtype)
			wtype_set:   nxt = prev | wdata;
			wtype_clear: nxt = prev & ~wdata;
			default:     nxt = wdata;
		endcase
		return (nxt & wmask) | (prev & ~wmask);
	endfunction

endpackage

//--- design/csr_read_mux.sv
// ID register constants, merge of bank read data and illegal access detection
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_read_mux (
	csr_access_if.bank          bus,
	input  csr_trap_pkg::xlen_t trap_rdata,
	input  logic                trap_hit,
	input  csr_trap_pkg::xlen_t irq_rdata,
	input  logic                irq_hit,
	input  csr_trap_pkg::xlen_t ctr_rdata,
	input  logic                ctr_hit,
	output csr_trap_pkg::xlen_t rdata,
	output logic                illegal
);
	import csr_map_pkg::*;
	import csr_trap_pkg::*;

	xlen_t id_rdata;
	logic  id_hit;

	// ID registers are read only, a write misses
	always_comb begin
		id_rdata = '0;
		id_hit   = !bus.wen;
		case (bus.addr)
			ADDR_MVENDORID: id_rdata = `CSR_MVENDORID_VAL;
			ADDR_MARCHID:   id_rdata = `CSR_MARCHID_VAL;
			ADDR_MIMPID:    id_rdata = `CSR_MIMPID_VAL;
			ADDR_MHARTID:   id_rdata = `CSR_MHARTID_VAL;
			default:        id_hit   = 1'b0;
		endcase
	end

	// Banks drive zero when not addressed
	assign rdata = id_rdata | trap_rdata | irq_rdata | ctr_rdata;

	// Unmapped address or write to a read-only register
	assign illegal = (bus.wen || bus.ren) && !(id_hit || trap_hit || irq_hit || ctr_hit);

endmodule

//--- design/csr_trap_pkg.sv
// Trap types: data word, exception codes, mcause code and interrupt number
package csr_trap_pkg;

	typedef logic [31:0] xlen_t; // RV32 data word

	// Exception request from the core
	// Values match the mcause code where one exists
	typedef enum logic [3:0] {
		except_instr_misalign = 4'h0,
		except_illegal_instr  = 4'h2,
		except_ebreak         = 4'h3,
		except_ecall          = 4'hb, // M-mode ecall
		except_mret           = 4'he, // Trap return
		except_none           = 4'hf  // Idle
	} except_e;

	typedef logic [5:0] cause_code_t; // mcause bits 5:0

	typedef logic [4:0] irq_num_t; // Index into a 32-bit pending word

endpackage

//--- design/csr_trap_regs.sv
// Trap CSRs (mstatus, mtvec, mepc, mcause, mie, mscratch) and trap request generation
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_trap_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	csr_access_if.bank            bus,
	irq_status_if.trap            irqs,
	input  logic                  trap_enter_rdy,
	input  csr_trap_pkg::xlen_t   mepc_in,
	input  csr_trap_pkg::except_e except,
	output csr_trap_pkg::xlen_t   rdata,
	output logic                  hit,
	output csr_trap_pkg::xlen_t   trap_addr,
	output logic                  trap_is_irq,
	output logic                  trap_enter_vld
);
	import csr_map_pkg::*;
	import csr_trap_pkg::*;

	logic        mstatus_mie;  // Global interrupt enable
	logic        mstatus_mpie; // Saved enable
	xlen_t       mtvec_reg;
	xlen_t       mepc;
	xlen_t       mscratch;
	xlen_t       mie;
	logic        mcause_irq;
	cause_code_t mcause_code;
	xlen_t       mstatus_rd, mcause_rd, mtvec_base, vec_off;
	xlen_t       mstatus_wr, mcause_wr;
	logic        is_mret, trap_take;

	assign mstatus_rd = {24'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
	assign mcause_rd  = {mcause_irq, 25'b0, mcause_code};
	assign mtvec_base = {mtvec_reg[31:2], 2'b00}; // Mode bits stripped
	assign mstatus_wr = csr_wr_merge(mstatus_rd, bus.wdata, bus.wtype, 32'h0000_0088);
	assign mcause_wr  = csr_wr_merge(mcause_rd, bus.wdata, bus.wtype, 32'h8000_003f);

	// --------------------------------------------------
	// Trap request
	// --------------------------------------------------
	assign trap_is_irq    = (except == except_none);   // Exceptions win over interrupts
	assign trap_enter_vld = !trap_is_irq || irqs.irq_active;
	assign is_mret        = (except == except_mret);
	assign trap_take      = trap_enter_vld && trap_enter_rdy;

	// Vectored mode offsets interrupts only
	assign vec_off   = (mtvec_reg[0] && trap_is_irq) ? xlen_t'({irqs.irq_cause, 2'b00}) : '0;
	assign trap_addr = is_mret ? mepc : mtvec_base + vec_off;

	assign irqs.mie         = mie;
	assign irqs.mstatus_mie = mstatus_mie;

	// --------------------------------------------------
	// Control state
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mtvec_reg    <= `CSR_MTVEC_INIT;
			mie          <= '0;
			mcause_irq   <= 1'b0;
			mcause_code  <= '0;
		end else begin
			if (trap_take && is_mret) begin // Pop enable stack
				mstatus_mie  <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
			end else if (trap_take) begin // Push enable stack and log cause
				mstatus_mpie <= mstatus_mie;
				mstatus_mie  <= 1'b0;
				mcause_irq   <= trap_is_irq;
				mcause_code  <= trap_is_irq ? irqs.irq_cause : cause_code_t'(except);
			end else if (bus.wen) begin
				if (bus.addr == ADDR_MSTATUS) begin
					mstatus_mpie <= mstatus_wr[7];
					mstatus_mie  <= mstatus_wr[3];
				end
				if (bus.addr == ADDR_MCAUSE) begin
					mcause_irq  <= mcause_wr[31];
					mcause_code <= mcause_wr[5:0];
				end
			end
			if (bus.wen && bus.addr == ADDR_MTVEC)
				mtvec_reg <= csr_wr_merge(mtvec_reg, bus.wdata, bus.wtype, `CSR_MTVEC_WMASK);
			if (bus.wen && bus.addr == ADDR_MIE)
				mie <= csr_wr_merge(mie, bus.wdata, bus.wtype, MIE_WMASK);
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (trap_take && !is_mret)
			mepc <= mepc_in & ~32'h1; // Halfword aligned
		else if (bus.wen && bus.addr == ADDR_MEPC)
			mepc <= csr_wr_merge(mepc, bus.wdata, bus.wtype, 32'hffff_fffe);
		if (bus.wen && bus.addr == ADDR_MSCRATCH)
			mscratch <= csr_wr_merge(mscratch, bus.wdata, bus.wtype, 32'hffff_ffff);
	end

	// --------------------------------------------------
	// Read decode
	// --------------------------------------------------
	always_comb begin
		rdata = '0;
		hit   = 1'b1;
		case (bus.addr)
			ADDR_MSTATUS:  rdata = mstatus_rd;
			ADDR_MIE:      rdata = mie;
			ADDR_MTVEC:    rdata = mtvec_reg;
			ADDR_MSCRATCH: rdata = mscratch;
			ADDR_MEPC:     rdata = mepc;
			ADDR_MCAUSE:   rdata = mcause_rd;
			ADDR_MTVAL:    rdata = '0;       // Hardwired zero
			ADDR_MIP:      rdata = irqs.mip; // Writes ignored
			default:       hit   = 1'b0;
		endcase
	end

endmodule

//--- design/csr_unit.sv
// Machine-mode CSR top level: access bus wiring and trap, IRQ, counter and read-mux instances
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	// CSR access port
	input  csr_map_pkg::csr_addr_t  addr,
	input  csr_trap_pkg::xlen_t     wdata,
	input  logic                    wen,
	input  logic                    ren,
	input  csr_map_pkg::csr_wtype_e wtype,
	output csr_trap_pkg::xlen_t     rdata,
	output logic                    illegal,
	// Trap entry handshake
	output csr_trap_pkg::xlen_t     trap_addr,
	output logic                    trap_is_irq,
	output logic                    trap_enter_vld,
	input  logic                    trap_enter_rdy,
	input  csr_trap_pkg::xlen_t     mepc_in,
	input  csr_trap_pkg::except_e   except,
	// Level interrupts and retire strobe
	input  logic [`CSR_NUM_IRQ-1:0] irq,
	input  logic                    irq_software,
	input  logic                    irq_timer,
	input  logic                    instr_ret
);
	import csr_trap_pkg::*;

	xlen_t trap_rdata, irq_rdata, ctr_rdata;
	logic  trap_hit, irq_hit, ctr_hit;

	csr_access_if csr_bus ();
	irq_status_if irq_stat ();

	// Plain ports onto the shared bus
	assign csr_bus.addr  = addr;
	assign csr_bus.wdata = wdata;
	assign csr_bus.wen   = wen;
	assign csr_bus.ren   = ren;
	assign csr_bus.wtype = wtype;

	csr_trap_regs u_trap_regs (
		.clk(clk), .rst_n(rst_n), .bus(csr_bus), .irqs(irq_stat),
		.trap_enter_rdy(trap_enter_rdy), .mepc_in(mepc_in), .except(except),
		.rdata(trap_rdata), .hit(trap_hit),
		.trap_addr(trap_addr), .trap_is_irq(trap_is_irq), .trap_enter_vld(trap_enter_vld)
	);

	csr_irq_ctrl u_irq_ctrl (
		.clk(clk), .rst_n(rst_n), .bus(csr_bus), .irqs(irq_stat),
		.irq(irq), .irq_software(irq_software), .irq_timer(irq_timer),
		.rdata(irq_rdata), .hit(irq_hit)
	);

	csr_counters u_counters (
		.clk(clk), .rst_n(rst_n), .bus(csr_bus), .instr_ret(instr_ret),
		.rdata(ctr_rdata), .hit(ctr_hit)
	);

	csr_read_mux u_read_mux (
		.bus(csr_bus),
		.trap_rdata(trap_rdata), .trap_hit(trap_hit),
		.irq_rdata(irq_rdata), .irq_hit(irq_hit),
		.ctr_rdata(ctr_rdata), .ctr_hit(ctr_hit),
		.rdata(rdata), .illegal(illegal)
	);

endmodule

//--- flist.f
+incdir+include
design/csr_map_pkg.sv
design/csr_trap_pkg.sv
design/csr_access_if.sv
design/csr_trap_regs.sv
design/csr_irq_ctrl.sv
design/csr_counters.sv
design/csr_read_mux.sv
design/csr_unit.sv
tests/csr_unit_tb.sv

//--- include/csr_cfg.svh
// Build-time constants for the CSR block: IRQ count, ID register values, mtvec reset and mask
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// --------------------------------------------------
// Interrupt configuration
// --------------------------------------------------
`define CSR_NUM_IRQ 16 // External interrupt lines, max 32

// --------------------------------------------------
// Machine information registers (read only)
// --------------------------------------------------
`define CSR_MVENDORID_VAL 32'h0000_0613 // Vendor ID
`define CSR_MARCHID_VAL   32'h0000_001b // Architecture ID
`define CSR_MIMPID_VAL    32'h0000_0102 // Implementation ID
`define CSR_MHARTID_VAL   32'h0000_0000 // Single hart

// --------------------------------------------------
// Trap vector
// --------------------------------------------------
`define CSR_MTVEC_INIT  32'h0000_0100 // Direct mode at reset
// Bit 1 is reserved and stays zero
`define CSR_MTVEC_WMASK 32'hffff_fffd

`endif

//--- run.sh
#!/bin/sh
# Build the CSR unit testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module csr_unit_tb \
	-f flist.f -o csr_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi
./obj_dir/csr_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

//--- tests/csr_unit_tb.sv
// Testbench for csr_unit: clock, reset, CSR access and trap tasks, assertion-based checks
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_unit_tb;
	import csr_map_pkg::*;
	import csr_trap_pkg::*;

	localparam csr_addr_t ADDR_UNMAPPED = 12'h7c0; // Custom RW space with nothing mapped
	localparam csr_addr_t ADDR_HPM3     = 12'hb03; // mhpmcounter3 is not implemented
	localparam xlen_t     TVEC_BASE     = 32'h0000_3000;
	localparam xlen_t     MSTATUS_MIE   = 32'h0000_0008; // Bit 3
	localparam xlen_t     MSTATUS_MPIE  = 32'h0000_0080; // Bit 7
	localparam int        CYC_GAP       = 7;  // Clocks between two mcycle reads
	localparam int        WAIT_LIMIT    = 20; // Cycles before a trap wait gives up

	logic                    clk;
	logic                    rst_n;
	csr_addr_t               addr;
	xlen_t                   wdata;
	logic                    wen;
	logic                    ren;
	csr_wtype_e              wtype;
	xlen_t                   rdata;
	logic                    illegal;
	xlen_t                   trap_addr;
	logic                    trap_is_irq;
	logic                    trap_enter_vld;
	logic                    trap_enter_rdy;
	xlen_t                   mepc_in;
	except_e                 except;
	logic [`CSR_NUM_IRQ-1:0] irq;
	logic                    irq_software;
	logic                    irq_timer;
	logic                    instr_ret;

	integer seed = 32'h361c;
	string  test_name;
	int     test_errs;
	int     pass_cnt;
	int     fail_cnt;
	xlen_t  rd_val;   // Captured by the last CSR access
	logic   rd_ill;
	xlen_t  cap_addr; // Captured by the last trap sample
	logic   cap_vld;
	logic   cap_irq;
	logic   cap_ill;

	csr_unit u_csr_unit (
		.clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata), .wen(wen), .ren(ren),
		.wtype(wtype), .rdata(rdata), .illegal(illegal), .trap_addr(trap_addr),
		.trap_is_irq(trap_is_irq), .trap_enter_vld(trap_enter_vld),
		.trap_enter_rdy(trap_enter_rdy), .mepc_in(mepc_in), .except(except), .irq(irq),
		.irq_software(irq_software), .irq_timer(irq_timer), .instr_ret(instr_ret)
	);

	always #5 clk = ~clk; // 10 ns period

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic tick(input int n);
		repeat (n) begin
			@(posedge clk);
			#1; // Drive point
		end
	endtask

	task automatic compare(input string what, input xlen_t exp, input xlen_t act);
		assert (act === exp)
		else begin
			$display("error %s: %s expected %h, actual %h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	// One bus cycle with outputs sampled mid-cycle
	task automatic bus_access(input csr_addr_t a, input xlen_t d, input csr_wtype_e wt,
			input logic we, input logic re);
		addr  = a;
		wdata = d;
		wtype = wt;
		wen   = we;
		ren   = re;
		#4;
		rd_val = rdata;
		rd_ill = illegal;
		tick(1);
		wen = 1'b0;
		ren = 1'b0;
	endtask

	task automatic read_reg(input csr_addr_t a);
		bus_access(a, '0, wtype_write, 1'b0, 1'b1);
	endtask

	task automatic write_reg(input csr_addr_t a, input xlen_t d, input csr_wtype_e wt);
		bus_access(a, d, wt, 1'b1, 1'b0);
	endtask

	// Legal read with a known result
	task automatic expect_reg(input csr_addr_t a, input xlen_t exp, input string what);
		read_reg(a);
		compare(what, exp, rd_val);
		compare({what, " illegal"}, 32'h0, 32'(rd_ill));
	endtask

	task automatic sample_trap();
		#4;
		cap_vld  = trap_enter_vld;
		cap_addr = trap_addr;
		cap_irq  = trap_is_irq;
		cap_ill  = illegal;
		tick(1);
	endtask

	task automatic wait_trap_vld(input int limit);
		int n;
		n       = 0;
		cap_vld = 1'b0;
		while (!cap_vld && n < limit) begin
			sample_trap();
			n++;
		end
		if (!cap_vld) begin
			$display("%s: trap_enter_vld did not rise within %0d cycles", test_name, limit);
			test_errs++;
		end
	endtask

	task automatic accept_trap(); // rdy high for one edge
		trap_enter_rdy = 1'b1;
		tick(1);
		trap_enter_rdy = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic close_test();
		if (test_errs == 0) begin
			$display("test %s ok", test_name);
			pass_cnt++;
		end else begin
			$display("test %s failed with %0d errors", test_name, test_errs);
			fail_cnt++;
		end
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic reset_and_rw();
		xlen_t r;
		xlen_t s;
		xlen_t c;
		start_test("reset_rw");
		sample_trap();
		compare("trap_enter_vld", 32'h0, 32'(cap_vld));
		compare("illegal", 32'h0, 32'(cap_ill));
		expect_reg(ADDR_MSTATUS, 32'h0, "mstatus");
		expect_reg(ADDR_MIE, 32'h0, "mie");
		expect_reg(ADDR_MEIE0, 32'h0, "meie0");
		expect_reg(ADDR_MTVEC, `CSR_MTVEC_INIT, "mtvec");
		r = $random(seed);
		s = $random(seed);
		c = $random(seed);
		write_reg(ADDR_MSCRATCH, r, wtype_write);
		expect_reg(ADDR_MSCRATCH, r, "mscratch write");
		write_reg(ADDR_MSCRATCH, s, wtype_set);
		expect_reg(ADDR_MSCRATCH, r | s, "mscratch set");
		write_reg(ADDR_MSCRATCH, c, wtype_clear);
		expect_reg(ADDR_MSCRATCH, (r | s) & ~c, "mscratch clear");
		write_reg(ADDR_MIE, 32'hffff_ffff, wtype_write);
		expect_reg(ADDR_MIE, 32'h0000_0888, "mie mask"); // Only meie, mtie, msie stick
		write_reg(ADDR_MIE, 32'h0, wtype_write);
		close_test();
	endtask

	task automatic illegal_access();
		start_test("illegal");
		read_reg(ADDR_UNMAPPED);
		compare("unmapped read", 32'h1, 32'(rd_ill));
		read_reg(ADDR_HPM3);
		compare("hpm read", 32'h1, 32'(rd_ill));
		write_reg(ADDR_MVENDORID, 32'h5a5a_5a5a, wtype_write);
		compare("mvendorid write", 32'h1, 32'(rd_ill));
		write_reg(ADDR_MLEI, 32'h1, wtype_write);
		compare("mlei write", 32'h1, 32'(rd_ill));
		expect_reg(ADDR_MVENDORID, `CSR_MVENDORID_VAL, "mvendorid");
		expect_reg(ADDR_MARCHID, `CSR_MARCHID_VAL, "marchid");
		expect_reg(ADDR_MIMPID, `CSR_MIMPID_VAL, "mimpid");
		expect_reg(ADDR_MHARTID, `CSR_MHARTID_VAL, "mhartid");
		close_test();
	endtask

	task automatic counter_behavior();
		xlen_t v1;
		xlen_t v2;
		int    pulses;
		start_test("counters");
		read_reg(ADDR_MCYCLE);
		v1 = rd_val;
		tick(CYC_GAP - 1); // Read itself takes one clock
		read_reg(ADDR_MCYCLE);
		v2 = rd_val;
		compare("mcycle delta", 32'(CYC_GAP), v2 - v1);
		write_reg(ADDR_MCOUNTINHIBIT, 32'h1, wtype_write); // cy
		read_reg(ADDR_MCYCLE);
		v1 = rd_val;
		tick(CYC_GAP - 1);
		read_reg(ADDR_MCYCLE);
		v2 = rd_val;
		compare("mcycle inhibited", 32'h0, v2 - v1);
		write_reg(ADDR_MCOUNTINHIBIT, 32'h0, wtype_write);
		read_reg(ADDR_MINSTRET);
		v1     = rd_val;
		pulses = 0;
		for (int i = 0; i < 10; i++) begin
			instr_ret = (i % 3 != 0); // Uneven retire pattern
			if (instr_ret)
				pulses++;
			tick(1);
		end
		instr_ret = 1'b0;
		read_reg(ADDR_MINSTRET);
		v2 = rd_val;
		compare("minstret delta", 32'(pulses), v2 - v1);
		v1 = $random(seed);
		write_reg(ADDR_MCYCLEH, v1, wtype_write);
		expect_reg(ADDR_MCYCLEH, v1, "mcycleh");
		close_test();
	endtask

	task automatic exception_and_mret();
		start_test("exception_mret");
		write_reg(ADDR_MTVEC, TVEC_BASE, wtype_write); // Direct mode
		write_reg(ADDR_MSTATUS, MSTATUS_MIE, wtype_set);
		mepc_in = 32'h0000_1235; // Odd on purpose
		except  = except_ecall;
		wait_trap_vld(WAIT_LIMIT);
		compare("trap_is_irq", 32'h0, 32'(cap_irq));
		compare("trap_addr", TVEC_BASE, cap_addr);
		// Request must hold while rdy stays low
		repeat (4) begin
			sample_trap();
			compare("held vld", 32'h1, 32'(cap_vld));
			compare("held trap_addr", TVEC_BASE, cap_addr);
		end
		expect_reg(ADDR_MSTATUS, MSTATUS_MIE, "mstatus held");
		expect_reg(ADDR_MCAUSE, 32'h0, "mcause held");
		accept_trap();
		except = except_none;
		expect_reg(ADDR_MEPC, 32'h0000_1234, "mepc"); // Bit 0 dropped
		expect_reg(ADDR_MCAUSE, 32'd11, "mcause"); // M-mode ecall
		expect_reg(ADDR_MSTATUS, MSTATUS_MPIE, "mstatus on entry");
		except = except_mret;
		wait_trap_vld(WAIT_LIMIT);
		compare("mret trap_addr", 32'h0000_1234, cap_addr);
		accept_trap();
		except = except_none;
		expect_reg(ADDR_MSTATUS, MSTATUS_MIE | MSTATUS_MPIE, "mstatus after mret");
		write_reg(ADDR_MSTATUS, 32'h0, wtype_write);
		close_test();
	endtask

	task automatic external_irq();
		start_test("ext_irq");
		write_reg(ADDR_MEIE0, (32'h1 << 5) | (32'h1 << 9), wtype_write);
		irq[9] = 1'b1;
		irq[5] = 1'b1;
		tick(1); // Input register stage
		expect_reg(ADDR_MEIP0, (32'h1 << 5) | (32'h1 << 9), "meip0");
		expect_reg(ADDR_MLEI, 32'd5, "mlei");
		expect_reg(ADDR_MIP, 32'h1 << 11, "mip");
		write_reg(ADDR_MTVEC, TVEC_BASE | 32'h1, wtype_write); // Vectored
		write_reg(ADDR_MIE, 32'h1 << 11, wtype_write);
		mepc_in = 32'h0000_4000;
		write_reg(ADDR_MSTATUS, MSTATUS_MIE, wtype_set);
		wait_trap_vld(WAIT_LIMIT);
		compare("trap_is_irq", 32'h1, 32'(cap_irq));
		compare("trap_addr", TVEC_BASE + 4 * 32'd11, cap_addr);
		accept_trap();
		expect_reg(ADDR_MCAUSE, 32'h8000_0000 | 32'd11, "mcause");
		expect_reg(ADDR_MEPC, 32'h0000_4000, "mepc");
		irq = '0;
		write_reg(ADDR_MEIE0, 32'h0, wtype_write);
		close_test();
	endtask

	task automatic irq_priority();
		start_test("irq_priority");
		write_reg(ADDR_MIE, (32'h1 << 7) | (32'h1 << 3), wtype_write); // mtie, msie
		irq_software = 1'b1;
		irq_timer    = 1'b1;
		write_reg(ADDR_MSTATUS, MSTATUS_MIE, wtype_write);
		wait_trap_vld(WAIT_LIMIT);
		compare("software trap_is_irq", 32'h1, 32'(cap_irq));
		compare("software trap_addr", TVEC_BASE + 4 * 32'd3, cap_addr);
		irq_software = 1'b0;
		tick(1);
		sample_trap();
		compare("timer trap_addr", TVEC_BASE + 4 * 32'd7, cap_addr);
		accept_trap();
		expect_reg(ADDR_MCAUSE, 32'h8000_0000 | 32'd7, "mcause");
		irq_timer = 1'b0;
		close_test();
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		clk            = 1'b0;
		rst_n          = 1'b0;
		addr           = '0;
		wdata          = '0;
		wen            = 1'b0;
		ren            = 1'b0;
		wtype          = wtype_write;
		trap_enter_rdy = 1'b0;
		mepc_in        = '0;
		except         = except_none;
		irq            = '0;
		irq_software   = 1'b0;
		irq_timer      = 1'b0;
		instr_ret      = 1'b0;
		pass_cnt       = 0;
		fail_cnt       = 0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_and_rw();
		illegal_access();
		counter_behavior();
		exception_and_mret();
		external_irq();
		irq_priority();
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
